// ==== divSqrtUnit.f ====
logic/divSqrtPkg.sv
logic/divSqrtIf.sv
logic/divSqrtPreproc.sv
logic/divSqrtCtrl.sv
logic/divSqrtStage2.sv
logic/divSqrtIter.sv
logic/divSqrtPostproc.sv
logic/divSqrtUnit.sv
verif/divSqrtChecker.sv
verif/divSqrtTb.sv

// ==== verif/divSqrtStim.txt ====
# op (0 divide, 1 sqrt)  oddExp  a  b  expected result  expected sticky
# all hex, result is floor(2^24 * quotient or root), b unused for sqrt
0 0 000000 000000 1000000 0
0 0 7FFFFF 7FFFFF 1000000 0
0 0 400000 000000 1800000 0
0 0 100000 400000 0C00000 0
0 0 7FFFFF 000000 1FFFFFE 0
0 0 000000 400000 0AAAAAA 1
0 0 000000 200000 0CCCCCC 1
0 0 400000 200000 1333333 1
0 0 000000 600000 0924924 1
0 0 600000 400000 12AAAAA 1
0 0 000000 7FFFFF 0800000 1
1 0 000000 000000 1000000 0
1 0 480000 000000 1400000 0
1 0 720000 000000 1600000 0
1 1 100000 000000 1800000 0
1 1 440000 000000 1C00000 0
1 0 400000 000000 13988E1 1
1 0 200000 000000 11E3779 1
1 0 080000 000000 107E0F6 1
1 1 000000 000000 16A09E6 1
1 1 400000 000000 1BB67AE 1
1 1 500000 000000 1CD82B4 1

// ==== verif/divSqrtTb.sv ====
/*
 * Divide/square-root unit testbench
 * Reads operations from the stimulus file, drives the DUT and waits for done
 */
module divSqrtTb import divSqrtPkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int Copies = 1;
  localparam int N      = (DivBits + Copies - 1) / Copies;

  // One line of the stimulus file
  typedef struct packed {
    logic               isSqrt;
    logic               odd;
    fracT               a;
    fracT               b;
    logic [DivBits-1:0] res;
    logic               stk;
  } vecT;

  logic               clk;
  logic               reset;
  logic               start;
  logic               sqrt;
  logic               oddExp;
  fracT               a;
  fracT               b;
  logic               busy;
  logic               done;
  logic [DivBits-1:0] result;
  logic               sticky;

  vecT                vecs [$];
  int                 tbErrs;
  int                 limitCycles;
  int                 resultErrs;
  int                 stickyErrs;
  int                 ctrlErrs;
  int                 pendingOps;

  initial clk = 1'b0;
  always #10 clk = ~clk;

  divSqrtUnit #(.Copies(Copies)) DUT (
    .clk, .reset, .start, .sqrt, .oddExp, .a, .b, .busy, .done, .result, .sticky
  );

  divSqrtChecker #(.Copies(Copies)) resultChk (
    .clk, .reset, .start, .busy, .done, .result, .sticky,
    .resultCount(resultErrs), .stickyCount(stickyErrs), .ctrlCount(ctrlErrs),
    .pendingOps(pendingOps)
  );

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // Lines starting with # are column notes
  task automatic loadVectors();
    int          fd;
    int          rc;
    string       line;
    logic [31:0] fld [6];
    vecT         v;
    fd = $fopen("verif/divSqrtStim.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file verif/divSqrtStim.txt");
      tbErrs++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        rc = $fgets(line, fd);
        if (rc > 0 && line.getc(0) != "#") begin
          rc = $sscanf(line, "%h %h %h %h %h %h", fld[0], fld[1], fld[2], fld[3], fld[4], fld[5]);
          if (rc == 6) begin
            v.isSqrt = fld[0][0];
            v.odd    = fld[1][0];
            v.a      = fld[2][FracBits-1:0];
            v.b      = fld[3][FracBits-1:0];
            v.res    = fld[4][DivBits-1:0];
            v.stk    = fld[5][0];
            vecs.push_back(v);
          end else if (rc > 0) begin
            $display("Stimulus line could not be parsed: %s", line);
            tbErrs++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Issue one operation on the falling edge, then wait for done
  task automatic runOp(input int idx, input vecT v);
    string kind;
    if (v.isSqrt) begin
      kind = "sqrt";
    end else begin
      kind = "div";
    end
    resultChk.expectOp($sformatf("%s_%0d", kind, idx), v.res, v.stk);
    start  = 1'b1;
    sqrt   = v.isSqrt;
    oddExp = v.odd;
    a      = v.a;
    b      = v.b;
    @(negedge clk);
    start = 1'b0;
    // Some operations get a second start mid-run with other operands
    if (idx % 3 == 1) begin
      repeat (4) @(negedge clk);
      start  = 1'b1;
      sqrt   = ~v.isSqrt;
      oddExp = ~v.odd;
      a      = ~v.a;
      b      = ~v.b;
      @(negedge clk);
      start = 1'b0;
    end
    while (done !== 1'b1) begin
      @(negedge clk);
    end
  endtask

  task automatic printCounts();
    $display("Errors: result %0d, sticky %0d, control %0d, testbench %0d",
             resultErrs, stickyErrs, ctrlErrs, tbErrs);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    tbErrs      = 0;
    limitCycles = 0;
    reset       = 1'b1;
    start       = 1'b0;
    sqrt        = 1'b0;
    oddExp      = 1'b0;
    a           = '0;
    b           = '0;
    loadVectors();
    if (vecs.size() == 0) begin
      $display("No operations were read from the stimulus file");
      tbErrs++;
    end
    limitCycles = vecs.size() * (N + 4) + 40;
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    repeat (2) @(negedge clk);
    for (int i = 0; i < vecs.size(); i++) begin
      runOp(i, vecs[i]);
      // Even ones restart in the done cycle, odd ones idle first
      if (i % 2 == 1) begin
        repeat (3) @(negedge clk);
      end
    end
    repeat (3) @(negedge clk);
    @(posedge clk);
    if (pendingOps != 0) begin
      $display("%0d expected results were never compared", pendingOps);
      tbErrs++;
    end
    printCounts();
    if (resultErrs + stickyErrs + ctrlErrs + tbErrs == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Watchdog sized from the number of operations
  initial begin
    wait (limitCycles > 0);
    repeat (limitCycles) @(posedge clk);
    $display("Timeout after %0d cycles, done never arrived for the last operation",
             limitCycles);
    printCounts();
    $display("Finished with errors");
    $finish;
  end

endmodule

// ==== verif/divSqrtChecker.sv ====
/*
 * Divide/square-root result checker
 * Follows the start/busy/done timing and compares results with queued values
 */
module divSqrtChecker import divSqrtPkg::*; #(
  parameter int Copies = 1
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               start,
  input  logic               busy,
  input  logic               done,
  input  logic [DivBits-1:0] result,
  input  logic               sticky,
  output int                 resultCount,
  output int                 stickyCount,
  output int                 ctrlCount,
  output int                 pendingOps
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N = (DivBits + Copies - 1) / Copies;

  // Expected values in issue order
  string              nameQ   [$];
  logic [DivBits-1:0] resQ    [$];
  logic               stickyQ [$];

  // Edges since the accepted start, -1 while idle
  int                 edgeCnt    = -1;
  logic               busySeen   = 1'b0;
  logic               armed      = 1'b0;
  string              curName    = "reset";
  int                 resultErrs = 0;
  int                 stickyErrs = 0;
  int                 ctrlErrs   = 0;
  int                 pendCnt    = 0;
  logic               expBusy;
  logic               expDone;
  string              opName;
  logic [DivBits-1:0] expRes;
  logic               expStk;

  assign resultCount = resultErrs;
  assign stickyCount = stickyErrs;
  assign ctrlCount   = ctrlErrs;
  assign pendingOps  = pendCnt;

  // Called by the testbench when it issues an operation
  task automatic expectOp(input string name, input logic [DivBits-1:0] res, input logic stk);
    nameQ.push_back(name);
    resQ.push_back(res);
    stickyQ.push_back(stk);
  endtask

  ////////////////////////////////////////
  // Reference timing model
  ////////////////////////////////////////

  // Start counts only when the unit was not busy before this edge
  always @(posedge clk) begin
    if (reset) begin
      armed   = 1'b1;
      edgeCnt = -1;
    end else if (start && !busySeen) begin
      edgeCnt = 0;
      if (nameQ.size() > 0) begin
        curName = nameQ[0];
      end else begin
        curName = "unexpected";
      end
    end else if (edgeCnt >= 0 && edgeCnt <= N) begin
      edgeCnt = edgeCnt + 1;
    end
  end

  ////////////////////////////////////////
  // Comparisons on the falling edge
  ////////////////////////////////////////

  always @(negedge clk) begin
    if (armed) begin
      // Busy for N cycles, then one cycle of done
      expBusy = (edgeCnt >= 0) && (edgeCnt < N);
      expDone = (edgeCnt == N);
      if (busy !== expBusy) begin
        ctrlErrs++;
        $display("Error %s.busy expected %0b actual %0b", curName, expBusy, busy);
      end
      if (done !== expDone) begin
        ctrlErrs++;
        $display("Error %s.done expected %0b actual %0b", curName, expDone, done);
      end
      if (done === 1'b1) begin
        if (nameQ.size() == 0) begin
          ctrlErrs++;
          $display("Done pulsed at %0t ns while no operation was outstanding", $time);
        end else begin
          opName = nameQ.pop_front();
          expRes = resQ.pop_front();
          expStk = stickyQ.pop_front();
          if (result !== expRes) begin
            resultErrs++;
            $display("Error %s.result expected %h actual %h", opName, expRes, result);
          end
          if (sticky !== expStk) begin
            stickyErrs++;
            $display("Error %s.sticky expected %0b actual %0b", opName, expStk, sticky);
          end
        end
      end
    end
    busySeen = busy;
    pendCnt  = nameQ.size();
  end

endmodule

// ==== logic/divSqrtUnit.sv ====
/*
 * Radix-2 divide/square-root unit
 * Mantissa divide and square root by digit recurrence, start/busy/done control
 */
module divSqrtUnit import divSqrtPkg::*; #(
  parameter int Copies = 1
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               start,
  input  logic               sqrt,
  input  logic               oddExp,
  input  fracT               a,
  input  fracT               b,
  output logic               busy,
  output logic               done,
  output logic [DivBits-1:0] result,
  output logic               sticky
);

  rootT resultFull;

  divInitIf  initBus ();
  divStateIf stateBus ();

  // Operation strobe and mode straight onto the init bus
  assign initBus.load = start;
  assign initBus.sqrt = sqrt;

  divSqrtPreproc preproc (.a, .b, .sqrt, .oddExp, .init(initBus));

  divSqrtCtrl #(.Copies(Copies)) ctrl (
    .clk, .reset, .start, .state(stateBus), .busy, .done
  );

  divSqrtIter #(.Copies(Copies)) iter (.clk, .init(initBus), .state(stateBus));

  divSqrtPostproc postproc (.state(stateBus), .result(resultFull), .sticky);

  // Integer bit and 24 fraction bits, the last bit position is never set
  assign result = resultFull[DivBits:1];

endmodule

// ==== logic/divSqrtPostproc.sv ====
/*
 * Divide/square-root result selection
 * Resolves the residual sign to pick U or UM and forms sticky
 */
module divSqrtPostproc import divSqrtPkg::*; (
  divStateIf.post state,
  output rootT    result,
  output logic    sticky
);

  residualT wSum;
  logic     wNeg;

  ////////////////////////////////////////
  // Final residual
  ////////////////////////////////////////

  // One carry-propagate add of the carry-save pair
  assign wSum = state.ws + state.wc;

  // Negative residual means the last digits overshot by one ulp
  assign wNeg = wSum[ResBits-1];

  ////////////////////////////////////////
  // Result and sticky
  ////////////////////////////////////////

  // UM already holds U minus one ulp
  always_comb begin
    if (wNeg) begin
      result = state.um;
    end else begin
      result = state.u;
    end
  end

  // Any nonzero remainder makes the result inexact
  // a residual of exactly -d never occurs, so a negative one is never exact
  assign sticky = |wSum;

endmodule

// ==== logic/divSqrtIter.sv ====
/*
 * Divide/square-root iteration registers
 * Initial-value muxes, state registers and a chain of Copies radix-2 stages
 */
module divSqrtIter import divSqrtPkg::*; #(
  parameter int Copies = 1
) (
  input  logic    clk,
  divInitIf.iter  init,
  divStateIf.iter state
);

  // Digit weight register, Q2.DivBits
  localparam logic [DivBits+1:0] InitC = {2'b10, {DivBits{1'b0}}};

  residualT           wsReg, wcReg;
  rootT               uReg, umReg;
  logic [DivBits+1:0] cReg;
  divisorT            dReg;
  logic               sqrtReg;
  logic               loadAcc;

  // Chain nodes, index 0 is the register side
  residualT           wsChain [Copies+1];
  residualT           wcChain [Copies+1];
  rootT               uChain  [Copies+1];
  rootT               umChain [Copies+1];
  logic [DivBits+1:0] cChain  [Copies+1];
  divisorT            dBar;

  // A start during an operation is ignored
  assign loadAcc = init.load & ~state.iterEn;

  ////////////////////////////////////////
  // State registers
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (loadAcc) begin
      wsReg   <= init.x;
      wcReg   <= '0;
      // Both modes start with an empty result and weight 1 next
      uReg    <= '0;
      umReg   <= '0;
      cReg    <= InitC;
      dReg    <= init.dPre;
      sqrtReg <= init.sqrt;
    end else if (state.iterEn) begin
      wsReg <= wsChain[Copies];
      wcReg <= wcChain[Copies];
      uReg  <= uChain[Copies];
      umReg <= umChain[Copies];
      cReg  <= cChain[Copies];
    end
  end

  assign dBar = ~dReg;

  ////////////////////////////////////////
  // Recurrence chain
  ////////////////////////////////////////

  assign wsChain[0] = wsReg;
  assign wcChain[0] = wcReg;
  assign uChain[0]  = uReg;
  assign umChain[0] = umReg;
  assign cChain[0]  = cReg;

  for (genvar i = 0; i < Copies; i++) begin : gStage
    divSqrtStage2 stage (
      .d      (dReg),
      .dBar   (dBar),
      .sqrt   (sqrtReg),
      .ws     (wsChain[i]),
      .wc     (wcChain[i]),
      .c      (cChain[i]),
      .u      (uChain[i]),
      .um     (umChain[i]),
      .wsNext (wsChain[i+1]),
      .wcNext (wcChain[i+1]),
      .cNext  (cChain[i+1]),
      .uNext  (uChain[i+1]),
      .umNext (umChain[i+1])
    );
  end

  // State seen by postprocessing
  assign state.ws = wsReg;
  assign state.wc = wcReg;
  assign state.u  = uReg;
  assign state.um = umReg;

endmodule

// ==== logic/divSqrtStage2.sv ====
/*
 * Radix-2 divide/square-root step
 * Digit selection, carry-save residual update and on-the-fly conversion
 */
module divSqrtStage2 import divSqrtPkg::*; (
  input  divisorT            d,
  input  divisorT            dBar,
  input  logic               sqrt,
  input  residualT           ws,
  input  residualT           wc,
  input  logic [DivBits+1:0] c,
  input  rootT               u,
  input  rootT               um,
  output residualT           wsNext,
  output residualT           wcNext,
  output logic [DivBits+1:0] cNext,
  output rootT               uNext,
  output rootT               umNext
);

  logic [4:0] est;
  logic       wZero;
  logic       qp, qm;
  rootT       wt;
  rootT       fPlus, fMinus;
  residualT   addend;
  residualT   ws2, wc2;
  residualT   carry;

  ////////////////////////////////////////
  // Digit selection
  ////////////////////////////////////////

  // Estimate of 2w with one fraction bit
  assign est   = ws[ResBits-2:ResBits-6] + wc[ResBits-2:ResBits-6];
  // Exact zero residual when a^b equals (a|b)<<1
  assign wZero = ((ws ^ wc) == {ws[ResBits-2:0] | wc[ResBits-2:0], 1'b0});

  // +1 for est >= 0, 0 for est == -0.5 or zero residual, else -1
  assign qp = ~est[4] & ~wZero;
  assign qm = est[4] & (est != 5'b11111) & ~wZero;

  ////////////////////////////////////////
  // Subtrahend and residual update
  ////////////////////////////////////////

  // Weight shifts down one place
  // wt marks the digit being placed
  assign cNext = {c[DivBits+1], c[DivBits+1:1]};
  assign wt    = cNext[DivBits:0] & ~c[DivBits:0];

  // Sqrt term u + q*wt/2 uses the free low bits of u and um
  assign fPlus  = u | (wt >> 1);
  assign fMinus = um | wt | (wt >> 1);

  always_comb begin
    if (qp) begin
      // Subtract with the carry-in in the free carry LSB
      addend = sqrt ? ~{3'b000, fPlus} : {4'b1110, dBar};
    end else if (qm) begin
      addend = sqrt ? {3'b000, fMinus} : {4'b0001, d};
    end else begin
      addend = '0;
    end
  end

  assign ws2 = {ws[ResBits-2:0], 1'b0};
  assign wc2 = {wc[ResBits-2:0], qp};

  // 3:2 carry-save adder
  assign carry  = (ws2 & wc2) | (ws2 & addend) | (wc2 & addend);
  assign wsNext = ws2 ^ wc2 ^ addend;
  assign wcNext = {carry[ResBits-2:0], 1'b0};

  ////////////////////////////////////////
  // On-the-fly conversion
  ////////////////////////////////////////

  always_comb begin
    if (qp) begin
      uNext  = u | wt;
      umNext = u;
    end else if (qm) begin
      uNext  = um | wt;
      umNext = um;
    end else begin
      uNext  = u;
      umNext = um | wt;
    end
  end

endmodule

// ==== logic/divSqrtCtrl.sv ====
/*
 * Divide/square-root sequencer
 * Counts the recurrence cycles and produces busy, done and the step enable
 */
module divSqrtCtrl import divSqrtPkg::*; #(
  parameter int Copies = 1
) (
  input  logic  clk,
  input  logic  reset,
  input  logic  start,
  divStateIf.ctrl state,
  output logic  busy,
  output logic  done
);

  // Cycles needed for all result digits
  localparam int N       = (DivBits + Copies - 1) / Copies;
  localparam int CntBits = $clog2(N + 1);

  ctrlStateT          curState;
  logic [CntBits-1:0] count;

  ////////////////////////////////////////
  // State machine and iteration counter
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      curState <= IDLE;
      count    <= '0;
    end else begin
      case (curState)
        // Start accepted only when not iterating
        IDLE, DONE: begin
          if (start) begin
            curState <= BUSY;
            count    <= CntBits'(N);
          end else begin
            curState <= IDLE;
          end
        end
        BUSY: begin
          count <= count - 1'b1;
          // Last step this cycle
          if (count == CntBits'(1)) begin
            curState <= DONE;
          end
        end
        default: curState <= IDLE;
      endcase
    end
  end

  // Moore outputs, done lasts the single DONE cycle
  assign busy         = (curState == BUSY);
  assign done         = (curState == DONE);
  assign state.iterEn = busy;

endmodule

// ==== logic/divSqrtPreproc.sv ====
/*
 * Divide/square-root operand preprocessing
 * Forms the initial Q4 residual and the divisor fraction
 */
module divSqrtPreproc import divSqrtPkg::*; (
  input  fracT        a,
  input  fracT        b,
  input  logic        sqrt,
  input  logic        oddExp,
  divInitIf.pre       init
);

  residualT xHalf;
  residualT xQuarter;

  ////////////////////////////////////////
  // Initial residual
  ////////////////////////////////////////

  // Division starts from x/2 so the first digit carries weight 1
  // 1.a shifted right once lands in [0.5,1)
  assign xHalf = {4'b0000, 1'b1, a, 1'b0};

  // Square root starts from R/4
  // Even exponent gives R = 1.a, so 1.a/4 sits in [0.25,0.5)
  assign xQuarter = {4'b0000, 2'b01, a};

  // Odd exponent doubles R, which makes R/4 equal to 1.a/2
  always_comb begin
    if (sqrt && !oddExp) begin
      init.x = xQuarter;
    end else begin
      init.x = xHalf;
    end
  end

  ////////////////////////////////////////
  // Divisor
  ////////////////////////////////////////

  // Fraction of 1.b padded out to the residual fraction width
  // The hidden one is restored inside each stage
  assign init.dPre = {b, 2'b00};

endmodule

// ==== logic/divSqrtIf.sv ====
/*
 * Divide/square-root internal buses
 * Initial operand bus and per-cycle recurrence state bus
 */

// Initial residual, divisor and operation, valid with load
interface divInitIf import divSqrtPkg::*; ();
  residualT x;
  divisorT  dPre;
  logic     sqrt;
  logic     load;

  // Preprocessing drives the operands; load and sqrt come from the top
  modport pre (
    output x,
    output dPre
  );

  modport iter (
    input x,
    input dPre,
    input sqrt,
    input load
  );
endinterface

// Carry-save residual and on-the-fly result words
interface divStateIf import divSqrtPkg::*; ();
  residualT ws;
  residualT wc;
  rootT     u;
  rootT     um;
  // Step enable from the sequencer
  logic     iterEn;

  modport iter (
    output ws, wc, u, um,
    input  iterEn
  );

  modport ctrl (
    output iterEn
  );

  modport post (
    input ws, wc, u, um
  );
endinterface

// ==== logic/divSqrtPkg.sv ====
/*
 * Divide/square-root shared definitions
 * Width constants, datapath vector types and the sequencer state type
 */
package divSqrtPkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Operand fraction without the hidden one
  localparam int FracBits = 23;
  // Result digits produced by the recurrence
  localparam int DivBits  = FracBits + 2;
  // Residual in Q4 (4 integer bits, DivBits fraction bits)
  localparam int ResBits  = DivBits + 4;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  typedef logic [FracBits-1:0] fracT;
  // Fraction of the divisor 1.d, DivBits bits
  typedef logic [DivBits-1:0]  divisorT;
  // Residual sum or carry word
  typedef logic [ResBits-1:0]  residualT;
  // On-the-fly result words, U1.DivBits
  typedef logic [DivBits:0]    rootT;

  // Sequencer states
  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    DONE
  } ctrlStateT;

endpackage
